// File: rtl/router_regs_pkg.sv
// Shared sizes, register map and bus and counter types for the router register block.
// Referenced by scoped name from every RTL file of the block.
package router_regs_pkg;

    ////////////////////////////////////////////////////////////
    // Sizes and fixed values
    ////////////////////////////////////////////////////////////

    localparam int DATA_W = 32;
    localparam int ADDR_W = 8;
    localparam int CNT_W  = 32;

    localparam int NUM_ING_PORTS = 4;
    localparam int NUM_EGR_PORTS = 4;
    localparam int DATA_BYTES    = 64;
    localparam int MTU_BYTES     = 2000;

    // Ingress slot 0 is async FIFO overflow, slot 1 is buffer overflow
    localparam int ING_DROP_EVENTS = 2;
    localparam int EGR_DROP_EVENTS = 1;

    // Packet, byte and error counts from the datapath
    localparam int EXT_CNTRS          = 3;
    localparam int ING_CNTRS_PER_PORT = EXT_CNTRS + ING_DROP_EVENTS;
    localparam int EGR_CNTRS_PER_PORT = EXT_CNTRS + EGR_DROP_EVENTS;

    ////////////////////////////////////////////////////////////
    // Register map
    ////////////////////////////////////////////////////////////

    localparam int ING_CNT_BASE = 8;
    localparam int EGR_CNT_BASE = ING_CNT_BASE + NUM_ING_PORTS * ING_CNTRS_PER_PORT;
    localparam int TOTAL_REGS   = EGR_CNT_BASE + NUM_EGR_PORTS * EGR_CNTRS_PER_PORT;

    typedef enum logic [ADDR_W-1:0] {
        PARAMS0              = 8'd0,
        PARAMS1              = 8'd1,
        ING_PORT_ENABLE_CON  = 8'd2,
        EGR_PORT_ENABLE_CON  = 8'd3,
        ING_PORT_ENABLE_STAT = 8'd4,
        EGR_PORT_ENABLE_STAT = 8'd5,
        ING_COUNTER_CON      = 8'd6,
        EGR_COUNTER_CON      = 8'd7
    } reg_addr_e;

    ////////////////////////////////////////////////////////////
    // Types
    ////////////////////////////////////////////////////////////

    typedef enum logic {
        IDLE,
        RESP
    } ctrl_state_e;

    typedef struct packed {
        logic              write;
        logic [ADDR_W-1:0] addr;
        logic [DATA_W-1:0] wdata;
    } reg_req_t;

    typedef struct packed {
        logic [DATA_W-1:0] rdata;
        logic              err;
    } reg_rsp_t;

    // One port's counters as seen from the datapath
    typedef struct packed {
        logic [CNT_W-1:0] pkt;
        logic [CNT_W-1:0] bytes;
        logic [CNT_W-1:0] err;
    } port_cnts_t;

endpackage

// File: rtl/router_regs_ctrl.sv
// Register bus controller with handshake FSM, address decode and control and status registers.
// Drives the sample bits and read selects of the ingress and egress snapshot banks.
`timescale 1ns/1ps

module router_regs_ctrl (
    input  logic                                       core_clk_ifc,
    input  logic                                       peripheral_sresetn_core,
    input  router_regs_pkg::reg_req_t                  req,
    input  logic                                       req_valid,
    output logic                                       req_ready,
    output router_regs_pkg::reg_rsp_t                  rsp,
    output logic                                       rsp_valid,
    input  logic                                       rsp_ready,
    output logic [router_regs_pkg::NUM_ING_PORTS-1:0]  ing_ports_enable,
    output logic [router_regs_pkg::NUM_EGR_PORTS-1:0]  egr_ports_enable,
    input  logic [router_regs_pkg::NUM_ING_PORTS-1:0]  ing_ports_connected,
    input  logic [router_regs_pkg::NUM_EGR_PORTS-1:0]  egr_ports_connected,
    output logic [router_regs_pkg::NUM_ING_PORTS-1:0]  ing_sample,
    output logic [router_regs_pkg::NUM_EGR_PORTS-1:0]  egr_sample,
    output logic [router_regs_pkg::ADDR_W-1:0]         ing_rd_sel,
    output logic [router_regs_pkg::ADDR_W-1:0]         egr_rd_sel,
    input  logic [router_regs_pkg::DATA_W-1:0]         ing_rd_data,
    input  logic [router_regs_pkg::DATA_W-1:0]         egr_rd_data
);

    router_regs_pkg::ctrl_state_e state;

    logic                                      accept;
    logic                                      addr_ok;
    logic                                      ing_hit;
    logic                                      egr_hit;
    logic [router_regs_pkg::DATA_W-1:0]        rd_word;
    logic [router_regs_pkg::NUM_ING_PORTS-1:0] ing_en_con;
    logic [router_regs_pkg::NUM_EGR_PORTS-1:0] egr_en_con;
    logic [router_regs_pkg::NUM_ING_PORTS-1:0] ing_cnt_con;
    logic [router_regs_pkg::NUM_EGR_PORTS-1:0] egr_cnt_con;

    ////////////////////////////////////////////////////////////
    // Handshake FSM
    ////////////////////////////////////////////////////////////

    // One transaction in flight and no new request while a response waits
    assign req_ready = (state == router_regs_pkg::IDLE);
    assign rsp_valid = (state == router_regs_pkg::RESP);
    assign accept    = req_valid && req_ready;

    always_ff @(posedge core_clk_ifc) begin
        if (!peripheral_sresetn_core) begin
            state <= router_regs_pkg::IDLE;
        end else begin
            case (state)
                router_regs_pkg::IDLE: if (accept) state <= router_regs_pkg::RESP;
                router_regs_pkg::RESP: if (rsp_ready) state <= router_regs_pkg::IDLE;
                default:               state <= router_regs_pkg::IDLE;
            endcase
        end
    end

    // Response word is captured on the accept edge and held until taken
    always_ff @(posedge core_clk_ifc) begin
        if (accept) begin
            rsp.err   <= !addr_ok;
            rsp.rdata <= req.write ? '0 : rd_word;
        end
    end

    ////////////////////////////////////////////////////////////
    // Control registers
    ////////////////////////////////////////////////////////////

    always_ff @(posedge core_clk_ifc) begin
        if (!peripheral_sresetn_core) begin
            ing_en_con  <= '1;
            egr_en_con  <= '1;
            ing_cnt_con <= '0;
            egr_cnt_con <= '0;
        end else if (accept && req.write) begin
            case (req.addr)
                router_regs_pkg::ING_PORT_ENABLE_CON:
                    ing_en_con <= req.wdata[router_regs_pkg::NUM_ING_PORTS-1:0];
                router_regs_pkg::EGR_PORT_ENABLE_CON:
                    egr_en_con <= req.wdata[router_regs_pkg::NUM_EGR_PORTS-1:0];
                router_regs_pkg::ING_COUNTER_CON:
                    ing_cnt_con <= req.wdata[router_regs_pkg::NUM_ING_PORTS-1:0];
                router_regs_pkg::EGR_COUNTER_CON:
                    egr_cnt_con <= req.wdata[router_regs_pkg::NUM_EGR_PORTS-1:0];
                default: ;
            endcase
        end
    end

    assign ing_ports_enable = ing_en_con;
    assign egr_ports_enable = egr_en_con;
    assign ing_sample       = ing_cnt_con;
    assign egr_sample       = egr_cnt_con;

    ////////////////////////////////////////////////////////////
    // Address decode and read data
    ////////////////////////////////////////////////////////////

    assign addr_ok = req.addr < router_regs_pkg::ADDR_W'(router_regs_pkg::TOTAL_REGS);
    assign ing_hit = req.addr >= router_regs_pkg::ADDR_W'(router_regs_pkg::ING_CNT_BASE)
                  && req.addr <  router_regs_pkg::ADDR_W'(router_regs_pkg::EGR_CNT_BASE);
    assign egr_hit = req.addr >= router_regs_pkg::ADDR_W'(router_regs_pkg::EGR_CNT_BASE)
                  && addr_ok;

    // Selects are relative to each bank's base and parked at 0 outside the region
    assign ing_rd_sel = ing_hit
        ? req.addr - router_regs_pkg::ADDR_W'(router_regs_pkg::ING_CNT_BASE) : '0;
    assign egr_rd_sel = egr_hit
        ? req.addr - router_regs_pkg::ADDR_W'(router_regs_pkg::EGR_CNT_BASE) : '0;

    always_comb begin
        rd_word = '0;
        if (ing_hit) begin
            rd_word = ing_rd_data;
        end else if (egr_hit) begin
            rd_word = egr_rd_data;
        end else begin
            case (req.addr)
                router_regs_pkg::PARAMS0: rd_word = router_regs_pkg::DATA_W'({
                    8'(router_regs_pkg::DATA_BYTES),
                    8'(router_regs_pkg::NUM_EGR_PORTS),
                    8'(router_regs_pkg::NUM_ING_PORTS)});
                router_regs_pkg::PARAMS1:
                    rd_word = router_regs_pkg::DATA_W'(16'(router_regs_pkg::MTU_BYTES));
                router_regs_pkg::ING_PORT_ENABLE_CON:
                    rd_word = router_regs_pkg::DATA_W'(ing_en_con);
                router_regs_pkg::EGR_PORT_ENABLE_CON:
                    rd_word = router_regs_pkg::DATA_W'(egr_en_con);
                router_regs_pkg::ING_PORT_ENABLE_STAT:
                    rd_word = router_regs_pkg::DATA_W'(ing_ports_connected);
                router_regs_pkg::EGR_PORT_ENABLE_STAT:
                    rd_word = router_regs_pkg::DATA_W'(egr_ports_connected);
                router_regs_pkg::ING_COUNTER_CON:
                    rd_word = router_regs_pkg::DATA_W'(ing_cnt_con);
                router_regs_pkg::EGR_COUNTER_CON:
                    rd_word = router_regs_pkg::DATA_W'(egr_cnt_con);
                default: rd_word = '0;
            endcase
        end
    end

    // Held response must not move under back-pressure
    assert property (@(posedge core_clk_ifc) disable iff (!peripheral_sresetn_core)
        rsp_valid && !rsp_ready |=> rsp_valid && $stable(rsp));

    // Out-of-range writes leave every control register alone
    assert property (@(posedge core_clk_ifc) disable iff (!peripheral_sresetn_core)
        accept && req.write && !addr_ok
        |=> $stable({ing_en_con, egr_en_con, ing_cnt_con, egr_cnt_con}));

endmodule

// File: rtl/counter_snapshot_bank.sv
// Per-port counter snapshots taken on a rising sample bit, read back one word at a time.
// Used once for ingress and once for egress.
`timescale 1ns/1ps

module counter_snapshot_bank #(
    parameter int NUM_PORTS = 4,
    parameter int NUM_DROP  = 1
) (
    input  logic                                 core_clk_ifc,
    input  logic                                 peripheral_sresetn_core,
    input  logic [NUM_PORTS-1:0]                 sample,
    input  router_regs_pkg::port_cnts_t          ext_cnts [NUM_PORTS],
    input  logic [router_regs_pkg::CNT_W-1:0]    drop_cnts [NUM_PORTS][NUM_DROP],
    input  logic [router_regs_pkg::ADDR_W-1:0]   rd_sel,
    output logic [router_regs_pkg::DATA_W-1:0]   rd_data,
    output logic [NUM_PORTS-1:0]                 capture
);

    localparam int PER_PORT  = router_regs_pkg::EXT_CNTRS + NUM_DROP;
    localparam int NUM_WORDS = NUM_PORTS * PER_PORT;
    localparam int IDX_W     = $clog2(NUM_WORDS);

    logic [NUM_PORTS-1:0]              sample_d;
    logic [router_regs_pkg::CNT_W-1:0] snap [NUM_WORDS];

    // Capture pulse also tells the drop counter to restart
    assign capture = sample & ~sample_d;

    always_ff @(posedge core_clk_ifc) begin
        if (!peripheral_sresetn_core) begin
            sample_d <= '0;
            for (int w = 0; w < NUM_WORDS; w++) begin
                snap[w] <= '0;
            end
        end else begin
            sample_d <= sample;
            for (int p = 0; p < NUM_PORTS; p++) begin
                if (capture[p]) begin
                    snap[p*PER_PORT]     <= ext_cnts[p].pkt;
                    snap[p*PER_PORT + 1] <= ext_cnts[p].bytes;
                    snap[p*PER_PORT + 2] <= ext_cnts[p].err;
                    // Drop counts follow the external counters
                    for (int d = 0; d < NUM_DROP; d++) begin
                        snap[p*PER_PORT + router_regs_pkg::EXT_CNTRS + d] <= drop_cnts[p][d];
                    end
                end
            end
        end
    end

    assign rd_data = snap[rd_sel[IDX_W-1:0]];

    // Controller keeps the select inside this bank's region
    assert property (@(posedge core_clk_ifc) disable iff (!peripheral_sresetn_core)
        rd_sel < NUM_WORDS);

endmodule

// File: rtl/drop_event_counter.sv
// Counts rising edges of per-port drop event lines between snapshots.
// A port's counts restart when its snapshot is captured.
`timescale 1ns/1ps

module drop_event_counter #(
    parameter int NUM_PORTS  = 4,
    parameter int NUM_EVENTS = 1
) (
    input  logic                              core_clk_ifc,
    input  logic                              peripheral_sresetn_core,
    input  logic [NUM_EVENTS-1:0]             events [NUM_PORTS],
    input  logic [NUM_PORTS-1:0]              clear,
    output logic [router_regs_pkg::CNT_W-1:0] counts [NUM_PORTS][NUM_EVENTS]
);

    logic [NUM_EVENTS-1:0] events_d [NUM_PORTS];
    logic [NUM_EVENTS-1:0] rise     [NUM_PORTS];

    always_comb begin
        for (int p = 0; p < NUM_PORTS; p++) begin
            rise[p] = events[p] & ~events_d[p];
        end
    end

    always_ff @(posedge core_clk_ifc) begin
        if (!peripheral_sresetn_core) begin
            for (int p = 0; p < NUM_PORTS; p++) begin
                events_d[p] <= '0;
                for (int e = 0; e < NUM_EVENTS; e++) begin
                    counts[p][e] <= '0;
                end
            end
        end else begin
            for (int p = 0; p < NUM_PORTS; p++) begin
                events_d[p] <= events[p];
                for (int e = 0; e < NUM_EVENTS; e++) begin
                    // An edge in the clear cycle is kept for the next snapshot
                    if (clear[p]) begin
                        counts[p][e] <= router_regs_pkg::CNT_W'(rise[p][e]);
                    end else if (rise[p][e]) begin
                        counts[p][e] <= counts[p][e] + 1'b1;
                    end
                end
            end
        end
    end

endmodule

// File: rtl/router_regs.sv
// Top level of the router control and status registers.
// Connects the bus controller to the ingress and egress snapshot banks and drop counters.
`timescale 1ns/1ps

module router_regs (
    input  logic                                      core_clk_ifc,
    input  logic                                      peripheral_sresetn_core,
    input  router_regs_pkg::reg_req_t                 req,
    input  logic                                      req_valid,
    output logic                                      req_ready,
    output router_regs_pkg::reg_rsp_t                 rsp,
    output logic                                      rsp_valid,
    input  logic                                      rsp_ready,
    output logic [router_regs_pkg::NUM_ING_PORTS-1:0] ing_ports_enable,
    output logic [router_regs_pkg::NUM_EGR_PORTS-1:0] egr_ports_enable,
    input  logic [router_regs_pkg::NUM_ING_PORTS-1:0] ing_ports_connected,
    input  logic [router_regs_pkg::NUM_EGR_PORTS-1:0] egr_ports_connected,
    input  router_regs_pkg::port_cnts_t               ing_cnts [router_regs_pkg::NUM_ING_PORTS],
    input  router_regs_pkg::port_cnts_t               egr_cnts [router_regs_pkg::NUM_EGR_PORTS],
    input  logic [router_regs_pkg::NUM_ING_PORTS-1:0] ing_async_fifo_overflow,
    input  logic [router_regs_pkg::NUM_ING_PORTS-1:0] ing_buf_overflow,
    input  logic [router_regs_pkg::NUM_EGR_PORTS-1:0] egr_buf_full_drop
);

    logic [router_regs_pkg::NUM_ING_PORTS-1:0] ing_sample;
    logic [router_regs_pkg::NUM_EGR_PORTS-1:0] egr_sample;
    logic [router_regs_pkg::NUM_ING_PORTS-1:0] ing_capture;
    logic [router_regs_pkg::NUM_EGR_PORTS-1:0] egr_capture;
    logic [router_regs_pkg::ADDR_W-1:0]        ing_rd_sel;
    logic [router_regs_pkg::ADDR_W-1:0]        egr_rd_sel;
    logic [router_regs_pkg::DATA_W-1:0]        ing_rd_data;
    logic [router_regs_pkg::DATA_W-1:0]        egr_rd_data;

    logic [router_regs_pkg::ING_DROP_EVENTS-1:0] ing_events [router_regs_pkg::NUM_ING_PORTS];
    logic [router_regs_pkg::EGR_DROP_EVENTS-1:0] egr_events [router_regs_pkg::NUM_EGR_PORTS];
    logic [router_regs_pkg::CNT_W-1:0]
        ing_drop_cnts [router_regs_pkg::NUM_ING_PORTS][router_regs_pkg::ING_DROP_EVENTS];
    logic [router_regs_pkg::CNT_W-1:0]
        egr_drop_cnts [router_regs_pkg::NUM_EGR_PORTS][router_regs_pkg::EGR_DROP_EVENTS];

    // Event slot order matches the snapshot slot order
    for (genvar p = 0; p < router_regs_pkg::NUM_ING_PORTS; p++) begin : g_ing_ev
        assign ing_events[p] = {ing_buf_overflow[p], ing_async_fifo_overflow[p]};
    end
    for (genvar p = 0; p < router_regs_pkg::NUM_EGR_PORTS; p++) begin : g_egr_ev
        assign egr_events[p] = egr_buf_full_drop[p];
    end

    router_regs_ctrl ctrl_inst (
        .core_clk_ifc            (core_clk_ifc),
        .peripheral_sresetn_core (peripheral_sresetn_core),
        .req                     (req),
        .req_valid               (req_valid),
        .req_ready               (req_ready),
        .rsp                     (rsp),
        .rsp_valid               (rsp_valid),
        .rsp_ready               (rsp_ready),
        .ing_ports_enable        (ing_ports_enable),
        .egr_ports_enable        (egr_ports_enable),
        .ing_ports_connected     (ing_ports_connected),
        .egr_ports_connected     (egr_ports_connected),
        .ing_sample              (ing_sample),
        .egr_sample              (egr_sample),
        .ing_rd_sel              (ing_rd_sel),
        .egr_rd_sel              (egr_rd_sel),
        .ing_rd_data             (ing_rd_data),
        .egr_rd_data             (egr_rd_data)
    );

    ////////////////////////////////////////////////////////////
    // Ingress counters
    ////////////////////////////////////////////////////////////

    counter_snapshot_bank #(
        .NUM_PORTS (router_regs_pkg::NUM_ING_PORTS),
        .NUM_DROP  (router_regs_pkg::ING_DROP_EVENTS)
    ) ing_bank_inst (
        .core_clk_ifc            (core_clk_ifc),
        .peripheral_sresetn_core (peripheral_sresetn_core),
        .sample                  (ing_sample),
        .ext_cnts                (ing_cnts),
        .drop_cnts               (ing_drop_cnts),
        .rd_sel                  (ing_rd_sel),
        .rd_data                 (ing_rd_data),
        .capture                 (ing_capture)
    );

    drop_event_counter #(
        .NUM_PORTS  (router_regs_pkg::NUM_ING_PORTS),
        .NUM_EVENTS (router_regs_pkg::ING_DROP_EVENTS)
    ) ing_drop_inst (
        .core_clk_ifc            (core_clk_ifc),
        .peripheral_sresetn_core (peripheral_sresetn_core),
        .events                  (ing_events),
        .clear                   (ing_capture),
        .counts                  (ing_drop_cnts)
    );

    ////////////////////////////////////////////////////////////
    // Egress counters
    ////////////////////////////////////////////////////////////

    counter_snapshot_bank #(
        .NUM_PORTS (router_regs_pkg::NUM_EGR_PORTS),
        .NUM_DROP  (router_regs_pkg::EGR_DROP_EVENTS)
    ) egr_bank_inst (
        .core_clk_ifc            (core_clk_ifc),
        .peripheral_sresetn_core (peripheral_sresetn_core),
        .sample                  (egr_sample),
        .ext_cnts                (egr_cnts),
        .drop_cnts               (egr_drop_cnts),
        .rd_sel                  (egr_rd_sel),
        .rd_data                 (egr_rd_data),
        .capture                 (egr_capture)
    );

    drop_event_counter #(
        .NUM_PORTS  (router_regs_pkg::NUM_EGR_PORTS),
        .NUM_EVENTS (router_regs_pkg::EGR_DROP_EVENTS)
    ) egr_drop_inst (
        .core_clk_ifc            (core_clk_ifc),
        .peripheral_sresetn_core (peripheral_sresetn_core),
        .events                  (egr_events),
        .clear                   (egr_capture),
        .counts                  (egr_drop_cnts)
    );

endmodule

// File: test/router_regs_tb_tasks.svh
// Bus access tasks, model updates and test sequences for the router register testbench.
// Included inside the testbench module. Every task starts and ends on a falling edge.

task automatic abort_run(input string why);
    $display("%s", why);
    $display("Test failed");
    $fatal(1, "simulation stopped");
endtask

task automatic set_counters(input logic [31:0] val);
    for (int p = 0; p < NI; p++) begin
        ing_cnts[p] = {val, val, val};
    end
    for (int p = 0; p < NE; p++) begin
        egr_cnts[p] = {val, val, val};
    end
endtask

function automatic void model_reset();
    m_ing_en  = '1;
    m_egr_en  = '1;
    m_ing_con = '0;
    m_egr_con = '0;
    for (int p = 0; p < NI; p++) begin
        m_ing_snap[p] = '{default: '0};
        m_egr_snap[p] = '{default: '0};
        m_ing_drop[p] = '{default: '0};
        m_egr_drop[p] = '0;
    end
endfunction

// Rising sample bits copy the counters and restart the drop counts
function automatic void model_capture(input bit egr, input logic [NI-1:0] rise);
    for (int p = 0; p < NI; p++) begin
        if (rise[p] && !egr) begin
            m_ing_snap[p] = '{ing_cnts[p].pkt, ing_cnts[p].bytes, ing_cnts[p].err,
                              m_ing_drop[p][0], m_ing_drop[p][1]};
            m_ing_drop[p] = '{default: '0};
        end else if (rise[p] && egr) begin
            m_egr_snap[p] = '{egr_cnts[p].pkt, egr_cnts[p].bytes, egr_cnts[p].err,
                              m_egr_drop[p]};
            m_egr_drop[p] = '0;
        end
    end
endfunction

function automatic void model_write(input logic [7:0] addr, input logic [31:0] wdata);
    case (addr)
        router_regs_pkg::ING_PORT_ENABLE_CON: m_ing_en = wdata[NI-1:0];
        router_regs_pkg::EGR_PORT_ENABLE_CON: m_egr_en = wdata[NE-1:0];
        router_regs_pkg::ING_COUNTER_CON: begin
            model_capture(1'b0, wdata[NI-1:0] & ~m_ing_con);
            m_ing_con = wdata[NI-1:0];
        end
        router_regs_pkg::EGR_COUNTER_CON: begin
            model_capture(1'b1, wdata[NE-1:0] & ~m_egr_con);
            m_egr_con = wdata[NE-1:0];
        end
        default: ;
    endcase
endfunction

////////////////////////////////////////////////////////////
// Bus access
////////////////////////////////////////////////////////////

task automatic send_req(input logic wr, input logic [7:0] addr, input logic [31:0] wdata);
    int waited = 0;
    req       = {wr, addr, wdata};
    req_valid = 1'b1;
    while (!req_ready) begin
        @(negedge core_clk_ifc);
        waited++;
        if (waited > TIMEOUT) begin
            abort_run({"Request was never accepted in ", test_name});
        end
    end
    // Taken on the rising edge before this falling edge
    @(negedge core_clk_ifc);
    req_valid = 1'b0;
endtask

task automatic take_rsp();
    int waited = 0;
    while (!rsp_valid) begin
        @(negedge core_clk_ifc);
        waited++;
        if (waited > TIMEOUT) begin
            abort_run({"No response arrived in ", test_name});
        end
    end
    @(negedge core_clk_ifc);
endtask

task automatic read_expect(input logic [7:0] addr, input logic [31:0] rdata, input logic err);
    exp_rsp = {rdata, err};
    send_req(1'b0, addr, '0);
    take_rsp();
endtask

task automatic write_reg(input logic [7:0] addr, input logic [31:0] wdata);
    logic err;
    err     = addr >= 8'(router_regs_pkg::TOTAL_REGS);
    exp_rsp = {32'h0, err};
    send_req(1'b1, addr, wdata);
    if (!err) begin
        model_write(addr, wdata);
    end
    take_rsp();
endtask

task automatic check_bank(input bit egr);
    int per;
    int ports;
    per   = egr ? router_regs_pkg::EGR_CNTRS_PER_PORT : router_regs_pkg::ING_CNTRS_PER_PORT;
    ports = egr ? NE : NI;
    for (int p = 0; p < ports; p++) begin
        for (int s = 0; s < per; s++) begin
            if (egr) begin
                read_expect(8'(router_regs_pkg::EGR_CNT_BASE + p*per + s), m_egr_snap[p][s], 1'b0);
            end else begin
                read_expect(8'(router_regs_pkg::ING_CNT_BASE + p*per + s), m_ing_snap[p][s], 1'b0);
            end
        end
    end
endtask

// One high cycle then one low cycle on every drop line of a port
task automatic pulse_drops(input int p);
    ing_async_fifo_overflow[p] = 1'b1;
    ing_buf_overflow[p]        = 1'b1;
    egr_buf_full_drop[p]       = 1'b1;
    @(negedge core_clk_ifc);
    ing_async_fifo_overflow[p] = 1'b0;
    ing_buf_overflow[p]        = 1'b0;
    egr_buf_full_drop[p]       = 1'b0;
    @(negedge core_clk_ifc);
    m_ing_drop[p][0]++;
    m_ing_drop[p][1]++;
    m_egr_drop[p]++;
endtask

////////////////////////////////////////////////////////////
// Test sequences
////////////////////////////////////////////////////////////

task automatic probe_reset_map();
    test_name = "reset_map";
    read_expect(router_regs_pkg::PARAMS0, 32'h0040_0404, 1'b0);
    read_expect(router_regs_pkg::PARAMS1, 32'd2000, 1'b0);
    check_bank(1'b0);
    check_bank(1'b1);
    read_expect(8'd44, 32'h0, 1'b1);
    write_reg(router_regs_pkg::PARAMS0, 32'hFFFF_FFFF);
    read_expect(router_regs_pkg::PARAMS0, 32'h0040_0404, 1'b0);
endtask

task automatic toggle_port_enables();
    test_name = "port_enables";
    write_reg(router_regs_pkg::ING_PORT_ENABLE_CON, $random(seed));
    write_reg(router_regs_pkg::EGR_PORT_ENABLE_CON, $random(seed));
    read_expect(router_regs_pkg::ING_PORT_ENABLE_CON, 32'(m_ing_en), 1'b0);
    read_expect(router_regs_pkg::EGR_PORT_ENABLE_CON, 32'(m_egr_en), 1'b0);
    read_expect(router_regs_pkg::ING_PORT_ENABLE_STAT, 32'(m_ing_en), 1'b0);
    read_expect(router_regs_pkg::EGR_PORT_ENABLE_STAT, 32'(m_egr_en), 1'b0);
endtask

task automatic sample_counters(input bit egr);
    logic [7:0] con;
    con       = egr ? 8'(router_regs_pkg::EGR_COUNTER_CON) : 8'(router_regs_pkg::ING_COUNTER_CON);
    test_name = egr ? "egr_snapshot" : "ing_snapshot";
    set_counters(32'h0);
    write_reg(con, 32'hFFFF_FFFF);
    check_bank(egr);
    set_counters(32'hAAAA_AAAA);
    write_reg(con, 32'h0);
    write_reg(con, $random(seed));
    check_bank(egr);
endtask

task automatic count_drops();
    test_name = "drop_counts";
    for (int p = 0; p < NI; p++) begin
        repeat (p + 1) pulse_drops(p);
    end
    for (int round = 0; round < 2; round++) begin
        write_reg(router_regs_pkg::ING_COUNTER_CON, 32'h0);
        write_reg(router_regs_pkg::EGR_COUNTER_CON, 32'h0);
        write_reg(router_regs_pkg::ING_COUNTER_CON, 32'hFFFF_FFFF);
        write_reg(router_regs_pkg::EGR_COUNTER_CON, 32'hFFFF_FFFF);
        check_bank(1'b0);
        check_bank(1'b1);
    end
endtask

task automatic stall_response();
    int hold;
    hold      = 1 + ($unsigned($random(seed)) % 8);
    test_name = "back_pressure";
    rsp_ready = 1'b0;
    exp_rsp   = {32'd2000, 1'b0};
    send_req(1'b0, router_regs_pkg::PARAMS1, '0);
    // Second request waits behind the held response
    req       = {1'b0, 8'(router_regs_pkg::ING_PORT_ENABLE_CON), 32'h0};
    req_valid = 1'b1;
    repeat (hold) @(negedge core_clk_ifc);
    rsp_ready = 1'b1;
    @(negedge core_clk_ifc);
    exp_rsp = {32'(m_ing_en), 1'b0};
    send_req(1'b0, router_regs_pkg::ING_PORT_ENABLE_CON, '0);
    take_rsp();
endtask

// File: test/router_regs_tb.sv
// Testbench for the router register block with a reference model and response checks.
// Bus tasks and test sequences are pulled in from the tasks header.
`timescale 1ns/1ps

module router_regs_tb;

    localparam int NI      = router_regs_pkg::NUM_ING_PORTS;
    localparam int NE      = router_regs_pkg::NUM_EGR_PORTS;
    localparam int TIMEOUT = 50;

    logic                        core_clk_ifc = 1'b0;
    logic                        peripheral_sresetn_core;
    router_regs_pkg::reg_req_t   req;
    logic                        req_valid;
    logic                        req_ready;
    router_regs_pkg::reg_rsp_t   rsp;
    logic                        rsp_valid;
    logic                        rsp_ready;
    logic [NI-1:0]               ing_ports_enable;
    logic [NE-1:0]               egr_ports_enable;
    router_regs_pkg::port_cnts_t ing_cnts [NI];
    router_regs_pkg::port_cnts_t egr_cnts [NE];
    logic [NI-1:0]               ing_async_fifo_overflow;
    logic [NI-1:0]               ing_buf_overflow;
    logic [NE-1:0]               egr_buf_full_drop;

    ////////////////////////////////////////////////////////////
    // Reference model state
    ////////////////////////////////////////////////////////////

    router_regs_pkg::reg_rsp_t exp_rsp;
    logic [NI-1:0] m_ing_en;
    logic [NE-1:0] m_egr_en;
    logic [NI-1:0] m_ing_con;
    logic [NE-1:0] m_egr_con;
    logic [31:0]   m_ing_snap [NI][router_regs_pkg::ING_CNTRS_PER_PORT];
    logic [31:0]   m_egr_snap [NE][router_regs_pkg::EGR_CNTRS_PER_PORT];
    logic [31:0]   m_ing_drop [NI][router_regs_pkg::ING_DROP_EVENTS];
    logic [31:0]   m_egr_drop [NE];

    string test_name;
    int    seed = 32'h7f37_522e;

    `include "router_regs_tb_tasks.svh"

    initial begin
        forever #10 core_clk_ifc = ~core_clk_ifc;
    end

    // Connected status is looped back from the enables
    router_regs router_regs_inst (
        .core_clk_ifc            (core_clk_ifc),
        .peripheral_sresetn_core (peripheral_sresetn_core),
        .req                     (req),
        .req_valid               (req_valid),
        .req_ready               (req_ready),
        .rsp                     (rsp),
        .rsp_valid               (rsp_valid),
        .rsp_ready               (rsp_ready),
        .ing_ports_enable        (ing_ports_enable),
        .egr_ports_enable        (egr_ports_enable),
        .ing_ports_connected     (ing_ports_enable),
        .egr_ports_connected     (egr_ports_enable),
        .ing_cnts                (ing_cnts),
        .egr_cnts                (egr_cnts),
        .ing_async_fifo_overflow (ing_async_fifo_overflow),
        .ing_buf_overflow        (ing_buf_overflow),
        .egr_buf_full_drop       (egr_buf_full_drop)
    );

    ////////////////////////////////////////////////////////////
    // Checks
    ////////////////////////////////////////////////////////////

    // Each completed response against the model
    a_rsp: assert property (@(posedge core_clk_ifc) disable iff (!peripheral_sresetn_core)
        rsp_valid && rsp_ready |-> rsp == exp_rsp)
        else abort_run($sformatf("ERR %s expected rdata %h err %0d actual rdata %h err %0d",
            test_name, $sampled(exp_rsp.rdata), $sampled(exp_rsp.err),
            $sampled(rsp.rdata), $sampled(rsp.err)));

    // Every accepted request is answered in the next cycle
    a_lat: assert property (@(posedge core_clk_ifc) disable iff (!peripheral_sresetn_core)
        req_valid && req_ready |=> rsp_valid)
        else abort_run({"No response in the cycle after the request was taken in ",
            test_name});

    // A held response stays put and blocks new requests
    a_hold: assert property (@(posedge core_clk_ifc) disable iff (!peripheral_sresetn_core)
        rsp_valid && !rsp_ready |=> $stable(rsp) && !req_ready)
        else abort_run({"Held response changed or a new request was taken in ", test_name});

    a_en: assert property (@(posedge core_clk_ifc) disable iff (!peripheral_sresetn_core)
        ing_ports_enable == m_ing_en && egr_ports_enable == m_egr_en)
        else abort_run($sformatf("ERR %s expected enables %h %h actual %h %h", test_name,
            $sampled(m_ing_en), $sampled(m_egr_en),
            $sampled(ing_ports_enable), $sampled(egr_ports_enable)));

    initial begin
        req                     = '0;
        req_valid               = 1'b0;
        rsp_ready               = 1'b1;
        peripheral_sresetn_core = 1'b0;
        exp_rsp                 = '0;
        ing_async_fifo_overflow = '0;
        ing_buf_overflow        = '0;
        egr_buf_full_drop       = '0;
        test_name               = "reset";
        set_counters(32'h0);
        model_reset();
        repeat (4) @(negedge core_clk_ifc);
        peripheral_sresetn_core = 1'b1;
        probe_reset_map();
        toggle_port_enables();
        sample_counters(1'b0);
        sample_counters(1'b1);
        count_drops();
        stall_response();
        $display("Test passed");
        $finish;
    end

endmodule

// File: router_regs.f
+incdir+test
rtl/router_regs_pkg.sv
rtl/router_regs_ctrl.sv
rtl/counter_snapshot_bank.sv
rtl/drop_event_counter.sv
rtl/router_regs.sv
test/router_regs_tb.sv

// File: run_sim.sh
#!/bin/sh
# Builds the router register testbench with Verilator, runs it and scans the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module router_regs_tb -f router_regs.f \
    -o router_regs_sim

./obj_dir/router_regs_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "Test failed" sim.log; then
    echo "Simulation reported a failure"
    exit 1
fi
if ! grep -q "Test passed" sim.log; then
    echo "Simulation ended without a result"
    exit 1
fi
echo "Simulation finished cleanly"
